// ==== ram_2p_ecc_top.f ====
source/ram_pkg.sv
source/secded_39_32_enc.sv
source/secded_39_32_dec.sv
source/ram_2p.sv
source/ram_2p_adv.sv
source/ecc_err_log.sv
source/ram_2p_ecc_top.sv
bench/ram_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the ram_2p_ecc_top testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f ram_2p_ecc_top.f \
    --top-module ram_tb -o ram_tb_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/ram_tb_sim); then
  echo "$sim_out"
  echo "Simulation exited with an error status"
  exit 1
fi

echo "$sim_out"

if grep -q "TEST RESULT: PASS" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

// ==== bench/ram_tb.sv ====
`default_nettype none

module ram_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import ram_pkg::*;

  localparam int DEPTH     = 256;
  localparam int AW        = $clog2(DEPTH);
  localparam int LIN       = 0;
  localparam int LOUT      = 0;
  localparam int CNTW      = 8;
  localparam int CNT_MAX   = (1 << CNTW) - 1;
  localparam int N_RAND    = 400;
  localparam int N_SINGLE  = 40;
  localparam int N_DOUBLE  = 20;
  localparam int N_SAT     = CNT_MAX + 8;
  localparam int DRAIN_MAX = 4 + LIN + LOUT;
  // Reset, init writes, every test body, the drains and some margin
  localparam int CYC_LIMIT = 5 + DEPTH / 2 + N_RAND + 2 * N_SINGLE + 4 * N_DOUBLE
                           + N_SAT + 8 + 6 * DRAIN_MAX + 50;

  typedef struct packed {
    int          due;
    logic [31:0] data;
    logic [1:0]  err;
    logic        chk_data;
  } rd_exp_t;

  logic clk_a_i, rst_a_ni;
  logic a_req_i, a_write_i, b_req_i, b_write_i, err_cnt_clr_i;
  logic [AW-1:0] a_addr_i, b_addr_i;
  logic [data_w-1:0] a_wdata_i, b_wdata_i, a_rdata_o, b_rdata_o;
  logic a_rvalid_o, b_rvalid_o;
  logic [1:0] a_rerror_o, b_rerror_o;
  inj_mode_e inj_mode_i;
  logic [inj_pos_w-1:0] inj_pos_i;
  logic [CNTW-1:0] a_corr_cnt_o, a_uncorr_cnt_o, b_corr_cnt_o, b_uncorr_cnt_o;

  // Reference model
  logic [31:0] mem_model [DEPTH];
  inj_mode_e   inj_model [DEPTH];
  rd_exp_t     exp_q [2][$];
  int          exp_corr [2];
  int          exp_uncorr [2];

  logic [15:0] lfsr_state = 16'd10900;
  int cyc = 0;
  int errors = 0;
  int checks = 0;
  int err_mark = 0;
  bit checking = 1'b0;

  ram_2p_ecc_top #(
    .Depth                (DEPTH),
    .EnableInputPipeline  (LIN != 0),
    .EnableOutputPipeline (LOUT != 0),
    .CntW                 (CNTW)
  ) u_ram_2p_ecc_top (
    .clk_a_i        (clk_a_i),
    .rst_a_ni       (rst_a_ni),
    .a_req_i        (a_req_i),
    .a_write_i      (a_write_i),
    .a_addr_i       (a_addr_i),
    .a_wdata_i      (a_wdata_i),
    .a_rdata_o      (a_rdata_o),
    .a_rvalid_o     (a_rvalid_o),
    .a_rerror_o     (a_rerror_o),
    .b_req_i        (b_req_i),
    .b_write_i      (b_write_i),
    .b_addr_i       (b_addr_i),
    .b_wdata_i      (b_wdata_i),
    .b_rdata_o      (b_rdata_o),
    .b_rvalid_o     (b_rvalid_o),
    .b_rerror_o     (b_rerror_o),
    .inj_mode_i     (inj_mode_i),
    .inj_pos_i      (inj_pos_i),
    .err_cnt_clr_i  (err_cnt_clr_i),
    .a_corr_cnt_o   (a_corr_cnt_o),
    .a_uncorr_cnt_o (a_uncorr_cnt_o),
    .b_corr_cnt_o   (b_corr_cnt_o),
    .b_uncorr_cnt_o (b_uncorr_cnt_o)
  );

  initial begin
    clk_a_i = 1'b0;
    forever #10 clk_a_i = ~clk_a_i;
  end

  // Cycle count and run limit
  always @(posedge clk_a_i) begin
    cyc <= cyc + 1;
    if (cyc >= CYC_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYC_LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Random numbers and checks
  ////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ 16'hB400;
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_bit()};
    end
    return r;
  endfunction

  function automatic int sat_inc(input int v);
    return (v >= CNT_MAX) ? v : v + 1;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cyc);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      $display("ERROR: %s (cycle %0d)", what, cyc);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("Test %-30s %s, %0d errors", name,
             (errors == err_mark) ? "passed" : "failed", errors - err_mark);
    err_mark = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_a_i);
    a_req_i       <= 1'b0;
    a_write_i     <= 1'b0;
    b_req_i       <= 1'b0;
    b_write_i     <= 1'b0;
    inj_mode_i    <= INJ_NONE;
    err_cnt_clr_i <= 1'b0;
  endtask

  // Drives one access and updates the model
  task automatic issue(input int p, input bit wr, input logic [AW-1:0] addr,
                       input logic [31:0] data, input inj_mode_e mode,
                       input logic [inj_pos_w-1:0] pos);
    rd_exp_t e;
    if (p == 0) begin
      a_req_i    <= 1'b1;
      a_write_i  <= wr;
      a_addr_i   <= addr;
      a_wdata_i  <= data;
      inj_mode_i <= mode;
      inj_pos_i  <= pos;
    end else begin
      b_req_i   <= 1'b1;
      b_write_i <= wr;
      b_addr_i  <= addr;
      b_wdata_i <= data;
    end
    if (wr) begin
      mem_model[addr] = data;
      inj_model[addr] = (p == 0) ? mode : INJ_NONE;
    end else begin
      e.due      = cyc + 2 + LIN + LOUT;
      e.data     = mem_model[addr];
      e.err      = (inj_model[addr] == INJ_SINGLE) ? 2'b01 :
                   (inj_model[addr] == INJ_DOUBLE) ? 2'b10 : 2'b00;
      e.chk_data = (inj_model[addr] != INJ_DOUBLE);
      exp_q[p].push_back(e);
    end
  endtask

  task automatic drain();
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      next_cycle();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////

  task automatic check_port(input int p, input logic rvalid, input logic [31:0] rdata,
                            input logic [1:0] rerror, input logic [CNTW-1:0] corr,
                            input logic [CNTW-1:0] uncorr);
    string   pfx;
    rd_exp_t e;
    pfx = (p == 0) ? "a" : "b";
    // Counters reflect pulses up to the previous cycle
    check_eq({pfx, "_corr_cnt_o"}, 32'(corr), 32'(exp_corr[p]));
    check_eq({pfx, "_uncorr_cnt_o"}, 32'(uncorr), 32'(exp_uncorr[p]));
    if (exp_q[p].size() != 0 && exp_q[p][0].due == cyc) begin
      e = exp_q[p].pop_front();
      check_true(rvalid == 1'b1, $sformatf("port %s rvalid missing for an issued read", pfx));
      if (e.chk_data) begin
        check_eq({pfx, "_rdata_o"}, rdata, e.data);
      end
      check_eq({pfx, "_rerror_o"}, 32'(rerror), 32'(e.err));
      if (e.err[err_corr_bit]) exp_corr[p] = sat_inc(exp_corr[p]);
      if (e.err[err_uncorr_bit]) exp_uncorr[p] = sat_inc(exp_uncorr[p]);
    end else begin
      check_true(rvalid == 1'b0, $sformatf("unexpected rvalid on port %s", pfx));
      check_eq({pfx, "_rerror_o"}, 32'(rerror), 32'd0);
    end
  endtask

  always @(negedge clk_a_i) begin
    if (checking) begin
      check_port(0, a_rvalid_o, a_rdata_o, a_rerror_o, a_corr_cnt_o, a_uncorr_cnt_o);
      check_port(1, b_rvalid_o, b_rdata_o, b_rerror_o, b_corr_cnt_o, b_uncorr_cnt_o);
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [AW-1:0] addr_a, addr_b;
    bit            req_a, req_b, wr_a, wr_b;
    int            p;
    rst_a_ni = 1'b0;
    a_req_i = 1'b0;
    a_write_i = 1'b0;
    a_addr_i = '0;
    a_wdata_i = '0;
    b_req_i = 1'b0;
    b_write_i = 1'b0;
    b_addr_i = '0;
    b_wdata_i = '0;
    inj_mode_i = INJ_NONE;
    inj_pos_i = '0;
    err_cnt_clr_i = 1'b0;
    exp_corr = '{0, 0};
    exp_uncorr = '{0, 0};
    repeat (3) @(posedge clk_a_i);
    rst_a_ni <= 1'b1;

    // Test 1: state right after reset
    @(negedge clk_a_i);
    check_true(!a_rvalid_o && !b_rvalid_o, "rvalid high after reset");
    check_eq("a_rerror_o", 32'(a_rerror_o), 32'd0);
    check_eq("b_rerror_o", 32'(b_rerror_o), 32'd0);
    check_eq("a_corr_cnt_o", 32'(a_corr_cnt_o), 32'd0);
    check_eq("a_uncorr_cnt_o", 32'(a_uncorr_cnt_o), 32'd0);
    check_eq("b_corr_cnt_o", 32'(b_corr_cnt_o), 32'd0);
    check_eq("b_uncorr_cnt_o", 32'(b_uncorr_cnt_o), 32'd0);
    next_cycle();
    checking = 1'b1;
    end_test("1 reset state");

    // Test 2: fill every word, then random traffic on both ports
    for (int i = 0; i < DEPTH / 2; i++) begin
      next_cycle();
      issue(0, 1'b1, AW'(2 * i), rand_bits(32), INJ_NONE, '0);
      issue(1, 1'b1, AW'(2 * i + 1), rand_bits(32), INJ_NONE, '0);
    end
    for (int i = 0; i < N_RAND; i++) begin
      next_cycle();
      req_a  = rand_bits(1) != 0;
      wr_a   = rand_bits(1) != 0;
      addr_a = AW'(rand_bits(AW));
      req_b  = rand_bits(1) != 0;
      wr_b   = rand_bits(1) != 0;
      addr_b = AW'(rand_bits(AW));
      // Keep the two ports off the same word when either one writes
      if (req_a && req_b && addr_a == addr_b && (wr_a || wr_b)) addr_b = addr_b + 1'b1;
      if (req_a) issue(0, wr_a, addr_a, rand_bits(32), INJ_NONE, '0);
      if (req_b) issue(1, wr_b, addr_b, rand_bits(32), INJ_NONE, '0);
    end
    drain();
    end_test("2 clean random traffic");

    // Test 3: single-bit injection is corrected
    for (int i = 0; i < N_SINGLE; i++) begin
      next_cycle();
      addr_a = AW'(rand_bits(AW));
      issue(0, 1'b1, addr_a, rand_bits(32), INJ_SINGLE, inj_pos_w'(rand_bits(6) % 39));
      next_cycle();
      p = int'(rand_bits(1));
      issue(p, 1'b0, addr_a, '0, INJ_NONE, '0);
    end
    drain();
    end_test("3 single-bit correction");

    // Test 4: double-bit injection is flagged, a clean rewrite clears it
    for (int i = 0; i < N_DOUBLE; i++) begin
      next_cycle();
      addr_a = AW'(rand_bits(AW));
      issue(0, 1'b1, addr_a, rand_bits(32), INJ_DOUBLE, inj_pos_w'(rand_bits(6) % 38));
      next_cycle();
      issue(int'(rand_bits(1)), 1'b0, addr_a, '0, INJ_NONE, '0);
      next_cycle();
      issue(1, 1'b1, addr_a, rand_bits(32), INJ_NONE, '0);
      next_cycle();
      issue(int'(rand_bits(1)), 1'b0, addr_a, '0, INJ_NONE, '0);
    end
    drain();
    end_test("4 double-bit detection");

    // Test 5: saturate the port A corrected count, then clear
    next_cycle();
    issue(0, 1'b1, AW'(5), rand_bits(32), INJ_SINGLE, inj_pos_w'(rand_bits(6) % 39));
    for (int i = 0; i < N_SAT; i++) begin
      next_cycle();
      issue(0, 1'b0, AW'(5), '0, INJ_NONE, '0);
    end
    drain();
    @(negedge clk_a_i);
    check_eq("a_corr_cnt_o", 32'(a_corr_cnt_o), 32'(CNT_MAX));
    next_cycle();
    err_cnt_clr_i <= 1'b1;
    next_cycle();
    exp_corr = '{0, 0};
    exp_uncorr = '{0, 0};
    @(negedge clk_a_i);
    check_eq("a_corr_cnt_o", 32'(a_corr_cnt_o), 32'd0);
    check_eq("b_uncorr_cnt_o", 32'(b_uncorr_cnt_o), 32'd0);
    next_cycle();
    end_test("5 counter saturation and clear");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule : ram_tb

`default_nettype wire

// ==== source/ram_2p_ecc_top.sv ====
`default_nettype none

module ram_2p_ecc_top #(
  parameter  int Depth                = 256,
  parameter  bit EnableInputPipeline  = 1'b0,
  parameter  bit EnableOutputPipeline = 1'b0,
  parameter  int CntW                 = 8,
  localparam int Aw                   = $clog2(Depth)
) (
  input  logic                          clk_a_i,
  input  logic                          rst_a_ni,

  input  logic                          a_req_i,
  input  logic                          a_write_i,
  input  logic [Aw-1:0]                 a_addr_i,
  input  logic [ram_pkg::data_w-1:0]    a_wdata_i,
  output logic [ram_pkg::data_w-1:0]    a_rdata_o,
  output logic                          a_rvalid_o,
  output logic [1:0]                    a_rerror_o,

  input  logic                          b_req_i,
  input  logic                          b_write_i,
  input  logic [Aw-1:0]                 b_addr_i,
  input  logic [ram_pkg::data_w-1:0]    b_wdata_i,
  output logic [ram_pkg::data_w-1:0]    b_rdata_o,
  output logic                          b_rvalid_o,
  output logic [1:0]                    b_rerror_o,

  input  ram_pkg::inj_mode_e            inj_mode_i,
  input  logic [ram_pkg::inj_pos_w-1:0] inj_pos_i,

  input  logic                          err_cnt_clr_i,
  output logic [CntW-1:0]               a_corr_cnt_o,
  output logic [CntW-1:0]               a_uncorr_cnt_o,
  output logic [CntW-1:0]               b_corr_cnt_o,
  output logic [CntW-1:0]               b_uncorr_cnt_o
);

  ram_2p_adv #(
    .Depth                (Depth),
    .EnableInputPipeline  (EnableInputPipeline),
    .EnableOutputPipeline (EnableOutputPipeline)
  ) u_ram_2p_adv (
    .clk_a_i    (clk_a_i),
    .rst_a_ni   (rst_a_ni),
    .a_req_i    (a_req_i),
    .a_write_i  (a_write_i),
    .a_addr_i   (a_addr_i),
    .a_wdata_i  (a_wdata_i),
    .a_rdata_o  (a_rdata_o),
    .a_rvalid_o (a_rvalid_o),
    .a_rerror_o (a_rerror_o),
    .b_req_i    (b_req_i),
    .b_write_i  (b_write_i),
    .b_addr_i   (b_addr_i),
    .b_wdata_i  (b_wdata_i),
    .b_rdata_o  (b_rdata_o),
    .b_rvalid_o (b_rvalid_o),
    .b_rerror_o (b_rerror_o),
    .inj_mode_i (inj_mode_i),
    .inj_pos_i  (inj_pos_i)
  );

  ////////////////////////////////////////////////////////////
  // Error loggers, one per port
  ////////////////////////////////////////////////////////////

  ecc_err_log #(
    .CntW (CntW)
  ) u_err_log_a (
    .clk_a_i      (clk_a_i),
    .rst_a_ni     (rst_a_ni),
    .rvalid_i     (a_rvalid_o),
    .rerror_i     (a_rerror_o),
    .clr_i        (err_cnt_clr_i),
    .corr_cnt_o   (a_corr_cnt_o),
    .uncorr_cnt_o (a_uncorr_cnt_o)
  );

  ecc_err_log #(
    .CntW (CntW)
  ) u_err_log_b (
    .clk_a_i      (clk_a_i),
    .rst_a_ni     (rst_a_ni),
    .rvalid_i     (b_rvalid_o),
    .rerror_i     (b_rerror_o),
    .clr_i        (err_cnt_clr_i),
    .corr_cnt_o   (b_corr_cnt_o),
    .uncorr_cnt_o (b_uncorr_cnt_o)
  );

endmodule : ram_2p_ecc_top

`default_nettype wire

// ==== source/ecc_err_log.sv ====
`default_nettype none

module ecc_err_log #(
  parameter int CntW = 8
) (
  input  logic            clk_a_i,
  input  logic            rst_a_ni,
  input  logic            rvalid_i,
  input  logic [1:0]      rerror_i,
  input  logic            clr_i,
  output logic [CntW-1:0] corr_cnt_o,
  output logic [CntW-1:0] uncorr_cnt_o
);
  import ram_pkg::*;

  logic [1:0]           event_d;
  logic [1:0][CntW-1:0] cnt_q;

  // One counter per rerror flag, indexed like the flag itself
  assign event_d = rerror_i & {2{rvalid_i}};

  always_ff @(posedge clk_a_i or negedge rst_a_ni) begin
    if (!rst_a_ni) begin
      cnt_q <= '0;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        // Hold at all ones
        if (event_d[i] && (cnt_q[i] != {CntW{1'b1}})) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign corr_cnt_o   = cnt_q[err_corr_bit];
  assign uncorr_cnt_o = cnt_q[err_uncorr_bit];

endmodule : ecc_err_log

`default_nettype wire

// ==== source/ram_2p_adv.sv ====
`default_nettype none

module ram_2p_adv #(
  parameter  int Depth                = 256,
  parameter  bit EnableInputPipeline  = 1'b0,
  parameter  bit EnableOutputPipeline = 1'b0,
  localparam int Aw                   = $clog2(Depth)
) (
  input  logic                          clk_a_i,
  input  logic                          rst_a_ni,

  input  logic                          a_req_i,
  input  logic                          a_write_i,
  input  logic [Aw-1:0]                 a_addr_i,
  input  logic [ram_pkg::data_w-1:0]    a_wdata_i,
  output logic [ram_pkg::data_w-1:0]    a_rdata_o,
  output logic                          a_rvalid_o,
  output logic [1:0]                    a_rerror_o,

  input  logic                          b_req_i,
  input  logic                          b_write_i,
  input  logic [Aw-1:0]                 b_addr_i,
  input  logic [ram_pkg::data_w-1:0]    b_wdata_i,
  output logic [ram_pkg::data_w-1:0]    b_rdata_o,
  output logic                          b_rvalid_o,
  output logic [1:0]                    b_rerror_o,

  input  ram_pkg::inj_mode_e            inj_mode_i,
  input  logic [ram_pkg::inj_pos_w-1:0] inj_pos_i
);
  import ram_pkg::*;

  // Index 0 is port A and index 1 is port B
  logic [1:0][data_w-1:0] wdata_in;
  logic [1:0][code_w-1:0] code_enc;
  logic [code_w-1:0]      a_flip;

  logic [1:0]             req_d,   req_q;
  logic [1:0]             write_d, write_q;
  logic [1:0][Aw-1:0]     addr_d,  addr_q;
  logic [1:0][code_w-1:0] wdata_d, wdata_q;

  logic [1:0][code_w-1:0] rdata_sram;
  logic [1:0]             rvalid_sram_q;
  logic [1:0][data_w-1:0] rdata_d, rdata_q;
  logic [1:0][1:0]        rerror_d, rerror_m, rerror_q;
  logic [1:0]             rvalid_q;

  assign req_d    = {b_req_i, a_req_i};
  assign write_d  = {b_write_i, a_write_i};
  assign addr_d   = {b_addr_i, a_addr_i};
  assign wdata_in = {b_wdata_i, a_wdata_i};

  ////////////////////////////////////////////////////////////
  // Fault injection on port A
  ////////////////////////////////////////////////////////////

  // Out of range positions match no bit and flip nothing
  always_comb begin
    a_flip = '0;
    for (int i = 0; i < code_w; i++) begin
      if ((inj_mode_i == INJ_SINGLE || inj_mode_i == INJ_DOUBLE) &&
          i == int'(inj_pos_i)) begin
        a_flip[i] = 1'b1;
      end
      if (inj_mode_i == INJ_DOUBLE && i == int'(inj_pos_i) + 1) begin
        a_flip[i] = 1'b1;
      end
    end
  end

  // Port B codewords go to the array unchanged
  assign wdata_d[0] = code_enc[0] ^ a_flip;
  assign wdata_d[1] = code_enc[1];

  ////////////////////////////////////////////////////////////
  // Encode and decode per port
  ////////////////////////////////////////////////////////////

  for (genvar p = 0; p < 2; p++) begin : gen_port
    secded_39_32_enc u_enc (
      .data_i (wdata_in[p]),
      .code_o (code_enc[p])
    );

    secded_39_32_dec u_dec (
      .code_i (rdata_sram[p]),
      .data_o (rdata_d[p]),
      .err_o  (rerror_d[p])
    );

    // Flags only mean something alongside valid data
    assign rerror_m[p] = rerror_d[p] & {2{rvalid_sram_q[p]}};
  end

  if (EnableInputPipeline) begin : gen_in_reg
    always_ff @(posedge clk_a_i or negedge rst_a_ni) begin
      if (!rst_a_ni) begin
        req_q   <= '0;
        write_q <= '0;
        addr_q  <= '0;
        wdata_q <= '0;
      end else begin
        req_q   <= req_d;
        write_q <= write_d;
        addr_q  <= addr_d;
        wdata_q <= wdata_d;
      end
    end
  end else begin : gen_in_direct
    assign req_q   = req_d;
    assign write_q = write_d;
    assign addr_q  = addr_d;
    assign wdata_q = wdata_d;
  end

  ram_2p #(
    .Depth (Depth)
  ) u_mem (
    .clk_a_i   (clk_a_i),
    .a_req_i   (req_q[0]),
    .a_write_i (write_q[0]),
    .a_addr_i  (addr_q[0]),
    .a_wdata_i (wdata_q[0]),
    .a_rdata_o (rdata_sram[0]),
    .b_req_i   (req_q[1]),
    .b_write_i (write_q[1]),
    .b_addr_i  (addr_q[1]),
    .b_wdata_i (wdata_q[1]),
    .b_rdata_o (rdata_sram[1])
  );

  // Array data appears one cycle after a read request
  always_ff @(posedge clk_a_i or negedge rst_a_ni) begin
    if (!rst_a_ni) begin
      rvalid_sram_q <= '0;
    end else begin
      rvalid_sram_q <= req_q & ~write_q;
    end
  end

  if (EnableOutputPipeline) begin : gen_out_reg
    always_ff @(posedge clk_a_i or negedge rst_a_ni) begin
      if (!rst_a_ni) begin
        rvalid_q <= '0;
        rdata_q  <= '0;
        rerror_q <= '0;
      end else begin
        rvalid_q <= rvalid_sram_q;
        rdata_q  <= rdata_d;
        rerror_q <= rerror_m;
      end
    end
  end else begin : gen_out_direct
    assign rvalid_q = rvalid_sram_q;
    assign rdata_q  = rdata_d;
    assign rerror_q = rerror_m;
  end

  assign a_rdata_o  = rdata_q[0];
  assign a_rvalid_o = rvalid_q[0];
  assign a_rerror_o = rerror_q[0];
  assign b_rdata_o  = rdata_q[1];
  assign b_rvalid_o = rvalid_q[1];
  assign b_rerror_o = rerror_q[1];

endmodule : ram_2p_adv

`default_nettype wire

// ==== source/ram_2p.sv ====
`default_nettype none

module ram_2p #(
  parameter  int Depth = 256,
  localparam int Aw    = $clog2(Depth)
) (
  input  logic                       clk_a_i,

  input  logic                       a_req_i,
  input  logic                       a_write_i,
  input  logic [Aw-1:0]              a_addr_i,
  input  logic [ram_pkg::code_w-1:0] a_wdata_i,
  output logic [ram_pkg::code_w-1:0] a_rdata_o,

  input  logic                       b_req_i,
  input  logic                       b_write_i,
  input  logic [Aw-1:0]              b_addr_i,
  input  logic [ram_pkg::code_w-1:0] b_wdata_i,
  output logic [ram_pkg::code_w-1:0] b_rdata_o
);
  import ram_pkg::*;

  logic [code_w-1:0] mem [Depth];

  // Both ports share one clock, so one process handles the array
  always_ff @(posedge clk_a_i) begin
    if (a_req_i && a_write_i) begin
      mem[a_addr_i] <= a_wdata_i;
    end
    if (b_req_i && b_write_i) begin
      mem[b_addr_i] <= b_wdata_i;
    end
    // Read data is held until the next read on that port
    if (a_req_i && !a_write_i) begin
      a_rdata_o <= mem[a_addr_i];
    end
    if (b_req_i && !b_write_i) begin
      b_rdata_o <= mem[b_addr_i];
    end
  end

endmodule : ram_2p

`default_nettype wire

// ==== source/secded_39_32_dec.sv ====
`default_nettype none

module secded_39_32_dec (
  input  logic [ram_pkg::code_w-1:0] code_i,
  output logic [ram_pkg::data_w-1:0] data_o,
  output logic [1:0]                 err_o
);
  import ram_pkg::*;

  logic [par_w-1:0]  syndrome;
  logic [data_w-1:0] flip;
  logic              data_hit;
  logic              check_hit;

  ////////////////////////////////////////////////////////////
  // Syndrome
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < par_w; i++) begin
      syndrome[i] = code_i[data_w+i] ^ (^(code_i[data_w-1:0] & h_rows[i]));
    end
  end

  ////////////////////////////////////////////////////////////
  // Single-bit correction
  ////////////////////////////////////////////////////////////

  // A syndrome equal to the column of data bit j points at that bit
  always_comb begin : p_locate
    logic [par_w-1:0] col;
    flip = '0;
    for (int j = 0; j < data_w; j++) begin
      for (int i = 0; i < par_w; i++) begin
        col[i] = h_rows[i][j];
      end
      flip[j] = (syndrome == col);
    end
  end

  assign data_hit  = |flip;
  // Weight-1 syndrome: the error is in a check bit, data is intact
  assign check_hit = $onehot(syndrome);

  assign data_o = code_i[data_w-1:0] ^ flip;

  // Nonzero syndromes that match no column are double errors
  always_comb begin
    err_o                 = 2'b00;
    err_o[err_corr_bit]   = data_hit | check_hit;
    err_o[err_uncorr_bit] = (syndrome != '0) & ~(data_hit | check_hit);
  end

endmodule : secded_39_32_dec

`default_nettype wire

// ==== source/secded_39_32_enc.sv ====
`default_nettype none

module secded_39_32_enc (
  input  logic [ram_pkg::data_w-1:0] data_i,
  output logic [ram_pkg::code_w-1:0] code_o
);
  import ram_pkg::*;

  logic [par_w-1:0] parity;

  // Each check bit covers the data bits selected by its matrix row
  always_comb begin
    for (int i = 0; i < par_w; i++) begin
      parity[i] = ^(data_i & h_rows[i]);
    end
  end

  // Data sits in the low bits, check bits above it
  assign code_o = {parity, data_i};

endmodule : secded_39_32_enc

`default_nettype wire

// ==== source/ram_pkg.sv ====
`default_nettype none

package ram_pkg;

  // Word and codeword widths
  localparam int data_w    = 32;
  localparam int par_w     = 7;
  localparam int code_w    = data_w + par_w;
  localparam int inj_pos_w = 6;

  // Fault injection on port A writes
  typedef enum logic [1:0] {
    INJ_NONE   = 2'd0,
    INJ_SINGLE = 2'd1,
    INJ_DOUBLE = 2'd2
  } inj_mode_e;

  // Positions inside the 2-bit rerror flag
  localparam int err_corr_bit   = 0;
  localparam int err_uncorr_bit = 1;

  // Hsiao check matrix rows, one row per check bit
  // Data bit j uses the j-th weight-3 subset of the 7 rows in lexical order
  localparam logic [par_w-1:0][data_w-1:0] h_rows = {
    32'h69A4_6910,
    32'hD552_5488,
    32'hB2C9_3244,
    32'h8E38_8E22,
    32'h7E07_81E1,
    32'h01FF_801F,
    32'h0000_7FFF
  };

endpackage : ram_pkg

`default_nettype wire
